// ==== cbus_axi.f ====
+incdir+src
src/cbus_axi_pkg.sv
src/axi_if.sv
src/cbus_to_axi.sv
src/axi_sram.sv
src/cbus_axi_top.sv
dv/cbus_axi_tb.sv

// ==== dv/cbus_axi_tb.sv ====
`timescale 1ns/10ps

`include "cbus_axi_settings.svh"

module cbus_axi_tb import cbus_axi_pkg::*; ();

    localparam int num_entries = 17;
    localparam int wait_limit  = 200;
    localparam int idx_bits    = $clog2(`CBA_SRAM_WORDS);

    typedef logic [`CBA_CBUS_LEN_BITS:0] count_t;
    typedef logic [`CBA_DATA_WIDTH-1:0]  word_t;
    typedef logic [`CBA_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [idx_bits-1:0]         word_idx_t;

    logic        clk;
    logic        resetn;
    logic        cbus_valid;
    logic        cbus_is_write;
    addr_t       cbus_addr;
    cbus_order_t cbus_order;
    word_t       cbus_wdata;
    logic        cbus_okay;
    logic        cbus_last;
    word_t       cbus_rdata;

    // stimulus table with the expected beat count per transfer
    string       test_name [num_entries];
    logic        test_write[num_entries];
    addr_t       test_addr [num_entries];
    cbus_order_t test_order[num_entries];
    count_t      test_beats[num_entries];

    // reference copy of the SRAM contents
    word_t model_mem [`CBA_SRAM_WORDS];

    cbus_axi_top cbus_axi_top_i (
        .clk           (clk),
        .resetn        (resetn),
        .cbus_valid    (cbus_valid),
        .cbus_is_write (cbus_is_write),
        .cbus_addr     (cbus_addr),
        .cbus_order    (cbus_order),
        .cbus_wdata    (cbus_wdata),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic add_entry(input int n, input string name, input logic wr, input addr_t addr,
                             input cbus_order_t order, input count_t beats);
        test_name[n]  = name;
        test_write[n] = wr;
        test_addr[n]  = addr;
        test_order[n] = order;
        test_beats[n] = beats;
    endtask

    task automatic load_table();
        add_entry(0,  "wr_o0",          1'b1, 32'h000, 3'd0, 5'd1);
        add_entry(1,  "rd_o0",          1'b0, 32'h000, 3'd0, 5'd1);
        add_entry(2,  "wr_o1",          1'b1, 32'h040, 3'd1, 5'd2);
        add_entry(3,  "rd_o1",          1'b0, 32'h040, 3'd1, 5'd2);
        add_entry(4,  "wr_o2",          1'b1, 32'h080, 3'd2, 5'd4);
        add_entry(5,  "rd_o2",          1'b0, 32'h080, 3'd2, 5'd4);
        // two and four AXI rounds
        add_entry(6,  "wr_o3",          1'b1, 32'h100, 3'd3, 5'd8);
        add_entry(7,  "rd_o3",          1'b0, 32'h100, 3'd3, 5'd8);
        add_entry(8,  "wr_o4",          1'b1, 32'h200, 3'd4, 5'd16);
        add_entry(9,  "rd_o4",          1'b0, 32'h200, 3'd4, 5'd16);
        // newer data inside the order 4 block
        add_entry(10, "wr_overlap",     1'b1, 32'h208, 3'd2, 5'd4);
        add_entry(11, "rd_overlap",     1'b0, 32'h200, 3'd4, 5'd16);
        // runs past the top word and lands on words 0 to 3
        add_entry(12, "wr_wrap",        1'b1, 32'h3f0, 3'd3, 5'd8);
        add_entry(13, "rd_wrap",        1'b0, 32'h3f0, 3'd3, 5'd8);
        add_entry(14, "rd_wrapped_low", 1'b0, 32'h000, 3'd2, 5'd4);
        add_entry(15, "wr_single",      1'b1, 32'h044, 3'd0, 5'd1);
        add_entry(16, "rd_single",      1'b0, 32'h044, 3'd0, 5'd1);
    endtask

    // word slot for a beat with the byte address taken modulo the SRAM size
    function automatic word_idx_t model_index(input addr_t addr, input count_t beat);
        addr_t byte_addr;
        byte_addr = addr + (`CBA_ADDR_WIDTH'(beat) << 2);
        return byte_addr[idx_bits+1:2];
    endfunction

    // called right after a rising edge and returns at the falling edge of the final beat
    task automatic run_transfer(input int n);
        count_t    beats;
        int        idle_cycles;
        logic      done;
        logic      advance;
        word_idx_t idx;
        beats       = '0;
        idle_cycles = 0;
        done        = 1'b0;
        cbus_valid    <= 1'b1;
        cbus_is_write <= test_write[n];
        cbus_addr     <= test_addr[n];
        cbus_order    <= test_order[n];
        cbus_wdata    <= `CBA_DATA_WIDTH'($urandom());
        while (!done) begin
            @(negedge clk);
            advance = cbus_okay;
            if (cbus_okay) begin
                idx = model_index(test_addr[n], beats);
                if (test_write[n]) begin
                    model_mem[idx] = cbus_wdata;
                end else begin
                    check_word($sformatf("%s data beat %0d", test_name[n], beats),
                               model_mem[idx], cbus_rdata);
                end
                beats       = beats + count_t'(1);
                idle_cycles = 0;
                done        = cbus_last || (beats == test_beats[n]);
            end else begin
                check_flag($sformatf("%s last without okay", test_name[n]), 1'b0, cbus_last);
                idle_cycles++;
                if (idle_cycles >= wait_limit) begin
                    abort_run($sformatf("transfer %s hung, no okay for %0d cycles",
                                        test_name[n], wait_limit));
                end
            end
            if (!done) begin
                @(posedge clk);
                // next write word once the current one is taken
                if (advance && test_write[n]) begin
                    cbus_wdata <= `CBA_DATA_WIDTH'($urandom());
                end
            end
        end
        // an early last ends the loop short of the expected count
        check_count($sformatf("%s beat count", test_name[n]), test_beats[n], beats);
        check_flag($sformatf("%s last on final beat", test_name[n]), 1'b1, cbus_last);
    endtask

    initial begin
        void'($urandom(32'h2ed4));
        resetn        = 1'b1;
        cbus_valid    = 1'b0;
        cbus_is_write = 1'b0;
        cbus_addr     = '0;
        cbus_order    = '0;
        cbus_wdata    = '0;
        load_table();

        // okay and last stay low through 16 rising edges in reset
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            if (c == 15) begin
                resetn <= 1'b0;
            end
            @(negedge clk);
            check_flag("okay in reset", 1'b0, cbus_okay);
            check_flag("last in reset", 1'b0, cbus_last);
        end
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_flag("okay before request", 1'b0, cbus_okay);
            check_flag("last before request", 1'b0, cbus_last);
        end

        // each request follows the previous last with no gap
        for (int n = 0; n < num_entries; n++) begin
            @(posedge clk);
            run_transfer(n);
        end
        @(posedge clk);
        cbus_valid <= 1'b0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_flag("okay after final transfer", 1'b0, cbus_okay);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cbus_axi_tb -f cbus_axi.f \
    --Mdir obj_dir -o cbus_axi_sim

output=$(./obj_dir/cbus_axi_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TEST OK"; then
    exit 0
else
    exit 1
fi

// ==== src/axi_if.sv ====
`timescale 1ns/10ps

`include "cbus_axi_settings.svh"

interface axi_if import cbus_axi_pkg::*; ();

    // read address and write address
    logic      ar_valid;
    logic      ar_ready;
    axi_addr_t ar;
    logic      aw_valid;
    logic      aw_ready;
    axi_addr_t aw;

    // write data
    logic                       w_valid;
    logic                       w_ready;
    logic [`CBA_DATA_WIDTH-1:0] w_data;
    logic                       w_last;

    // read data
    logic                       r_valid;
    logic                       r_ready;
    logic [`CBA_DATA_WIDTH-1:0] r_data;
    logic                       r_last;

    // write response, always okay
    logic b_valid;
    logic b_ready;

    modport master (
        output ar_valid, ar,
        input  ar_ready,
        output aw_valid, aw,
        input  aw_ready,
        output w_valid, w_data, w_last,
        input  w_ready,
        input  r_valid, r_data, r_last,
        output r_ready,
        input  b_valid,
        output b_ready
    );

    modport slave (
        input  ar_valid, ar,
        output ar_ready,
        input  aw_valid, aw,
        output aw_ready,
        input  w_valid, w_data, w_last,
        output w_ready,
        output r_valid, r_data, r_last,
        input  r_ready,
        output b_valid,
        input  b_ready
    );

endinterface

// ==== src/axi_sram.sv ====
`timescale 1ns/10ps

`include "cbus_axi_settings.svh"

module axi_sram import cbus_axi_pkg::*; (
    input logic  clk,
    input logic  resetn,

    axi_if.slave axi
);

    localparam int idx_bits = $clog2(`CBA_SRAM_WORDS);

    typedef logic [idx_bits-1:0] word_idx_t;

    logic [`CBA_DATA_WIDTH-1:0] mem [`CBA_SRAM_WORDS];

    slave_state_e state;
    word_idx_t    word_idx;
    axi_len_t     burst_len;
    axi_len_t     beat_cnt;

    logic ar_hs;
    logic aw_hs;
    logic r_hs;
    logic w_hs;
    logic b_hs;

    // address channels only open while idle
    assign axi.ar_ready = state == sl_idle;
    assign axi.aw_ready = state == sl_idle;

    assign ar_hs = axi.ar_valid && axi.ar_ready;
    assign aw_hs = axi.aw_valid && axi.aw_ready;
    assign r_hs  = axi.r_valid && axi.r_ready;
    assign w_hs  = axi.w_valid && axi.w_ready;
    assign b_hs  = axi.b_valid && axi.b_ready;

    // read data straight from the current word
    assign axi.r_valid = state == sl_read_data;
    assign axi.r_data  = mem[word_idx];
    assign axi.r_last  = beat_cnt == burst_len;

    assign axi.w_ready = state == sl_write_data;
    assign axi.b_valid = state == sl_write_resp;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= sl_idle;
            beat_cnt <= '0;
        end else begin
            unique case (state)
                sl_idle: begin
                    // a read wins if both arrive together
                    if (ar_hs) begin
                        state    <= sl_read_data;
                        beat_cnt <= '0;
                    end else if (aw_hs) begin
                        state    <= sl_write_data;
                        beat_cnt <= '0;
                    end
                end

                sl_read_data: begin
                    if (r_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (axi.r_last) begin
                            state <= sl_idle;
                        end
                    end
                end

                sl_write_data: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (axi.w_last) begin
                            state <= sl_write_resp;
                        end
                    end
                end

                sl_write_resp: begin
                    if (b_hs) begin
                        state <= sl_idle;
                    end
                end
            endcase
        end
    end

    // burst start and length; the burst type is ignored, every burst steps
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            word_idx  <= axi.ar.addr[idx_bits+1:2];
            burst_len <= axi.ar.len;
        end else if (aw_hs) begin
            word_idx  <= axi.aw.addr[idx_bits+1:2];
            burst_len <= axi.aw.len;
        end else if (r_hs || w_hs) begin
            // wraps at the top of memory
            word_idx <= word_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            mem[word_idx] <= axi.w_data;
        end
    end

endmodule

// ==== src/cbus_axi_pkg.sv ====
`include "cbus_axi_settings.svh"

package cbus_axi_pkg;

    // bridge sequencing
    typedef enum logic [1:0] {
        br_idle,
        br_transfer,
        br_request,
        br_waiting
    } bridge_state_e;

    // SRAM slave sequencing
    typedef enum logic [1:0] {
        sl_idle,
        sl_read_data,
        sl_write_data,
        sl_write_resp
    } slave_state_e;

    // AXI burst type encoding
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    // log2 of the cache bus beat count
    typedef logic [2:0] cbus_order_t;

    typedef logic [`CBA_AXI_LEN_BITS-1:0] axi_len_t;

    // shared payload of the AR and AW channels
    typedef struct packed {
        logic [`CBA_ADDR_WIDTH-1:0] addr;
        axi_len_t                   len;
        logic [2:0]                 size;
        axi_burst_e                 burst;
    } axi_addr_t;

endpackage

// ==== src/cbus_axi_settings.svh ====
`ifndef CBUS_AXI_SETTINGS_SVH
`define CBUS_AXI_SETTINGS_SVH

// byte address and data beat width, one word each
`define CBA_ADDR_WIDTH 32
`define CBA_DATA_WIDTH 32

// cache bus beat counter, 16 beats at most so order is 0..4
`define CBA_CBUS_LEN_BITS 4

// AXI length field as used by the bridge, 4 beats per burst
`define CBA_AXI_LEN_BITS 2

// SRAM depth in words, word index wraps modulo this
`define CBA_SRAM_WORDS 256

`endif

// ==== src/cbus_axi_top.sv ====
`timescale 1ns/10ps

`include "cbus_axi_settings.svh"

module cbus_axi_top import cbus_axi_pkg::*; (
    input  logic                       clk,
    input  logic                       resetn,

    // cache bus
    input  logic                       cbus_valid,
    input  logic                       cbus_is_write,
    input  logic [`CBA_ADDR_WIDTH-1:0] cbus_addr,
    input  cbus_order_t                cbus_order,
    input  logic [`CBA_DATA_WIDTH-1:0] cbus_wdata,
    output logic                       cbus_okay,
    output logic                       cbus_last,
    output logic [`CBA_DATA_WIDTH-1:0] cbus_rdata
);

    axi_if axi_bus ();

    // cache bus to AXI bursts
    cbus_to_axi bridge_i (
        .clk           (clk),
        .resetn        (resetn),
        .cbus_valid    (cbus_valid),
        .cbus_is_write (cbus_is_write),
        .cbus_addr     (cbus_addr),
        .cbus_order    (cbus_order),
        .cbus_wdata    (cbus_wdata),
        .cbus_okay     (cbus_okay),
        .cbus_last     (cbus_last),
        .cbus_rdata    (cbus_rdata),
        .axi           (axi_bus.master)
    );

    // on-chip memory behind the AXI port
    axi_sram sram_i (
        .clk    (clk),
        .resetn (resetn),
        .axi    (axi_bus.slave)
    );

endmodule

// ==== src/cbus_to_axi.sv ====
`timescale 1ns/10ps

`include "cbus_axi_settings.svh"

module cbus_to_axi import cbus_axi_pkg::*; (
    input  logic                       clk,
    input  logic                       resetn,

    input  logic                       cbus_valid,
    input  logic                       cbus_is_write,
    input  logic [`CBA_ADDR_WIDTH-1:0] cbus_addr,
    input  cbus_order_t                cbus_order,
    input  logic [`CBA_DATA_WIDTH-1:0] cbus_wdata,
    output logic                       cbus_okay,
    output logic                       cbus_last,
    output logic [`CBA_DATA_WIDTH-1:0] cbus_rdata,

    axi_if.master                      axi
);

    localparam int round_bits = `CBA_CBUS_LEN_BITS - `CBA_AXI_LEN_BITS;
    localparam logic [2:0] beat_size = 3'($clog2(`CBA_DATA_WIDTH / 8));

    typedef logic [round_bits-1:0] round_t;

    // total beats minus one, split into rounds and per-burst length
    // order 4 gives 16 which drops out of the low bits and wraps to 15
    logic [`CBA_CBUS_LEN_BITS:0]   beat_total;
    logic [`CBA_CBUS_LEN_BITS-1:0] beats_m1;
    round_t                        num_round;
    axi_len_t                      burst_len;

    assign beat_total = (`CBA_CBUS_LEN_BITS + 1)'(1) << cbus_order;
    assign beats_m1   = beat_total[`CBA_CBUS_LEN_BITS-1:0] - `CBA_CBUS_LEN_BITS'(1);
    assign {num_round, burst_len} = beats_m1;

    // bytes covered by one burst
    logic [`CBA_ADDR_WIDTH-1:0] addr_step;
    assign addr_step = (`CBA_ADDR_WIDTH'(burst_len) + `CBA_ADDR_WIDTH'(1)) << 2;

    bridge_state_e              state;
    logic [`CBA_ADDR_WIDTH-1:0] current_addr;
    round_t                     round_cnt;
    axi_len_t                   len_cnt;

    // counters count down to zero
    logic is_last;
    logic is_final;
    assign is_last  = len_cnt == '0;
    assign is_final = is_last && round_cnt == '0;

    // handshakes on whichever direction the transfer uses
    logic addr_hs;
    logic beat_hs;
    logic b_hs;
    assign addr_hs = cbus_is_write ? (axi.aw_valid && axi.aw_ready)
                                   : (axi.ar_valid && axi.ar_ready);
    assign beat_hs = cbus_is_write ? (axi.w_valid && axi.w_ready)
                                   : (axi.r_valid && axi.r_ready);
    assign b_hs    = axi.b_valid && axi.b_ready;

    // address phase in idle straight from the cache bus, later from the register
    logic      addr_req;
    axi_addr_t addr_payload;

    assign addr_req = (state == br_request) || (state == br_idle && cbus_valid);

    always_comb begin
        addr_payload.addr  = (state == br_idle) ? cbus_addr : current_addr;
        addr_payload.len   = burst_len;
        addr_payload.size  = beat_size;
        addr_payload.burst = burst_incr;
    end

    assign axi.ar_valid = addr_req && !cbus_is_write;
    assign axi.aw_valid = addr_req && cbus_is_write;
    assign axi.ar       = addr_payload;
    assign axi.aw       = addr_payload;

    // data phase
    assign axi.w_valid = (state == br_transfer) && cbus_is_write;
    assign axi.w_data  = cbus_wdata;
    assign axi.w_last  = is_last;
    assign axi.r_ready = (state == br_transfer) && !cbus_is_write;
    assign axi.b_ready = state == br_waiting;

    // the last W beat of each burst is acknowledged with its B response
    assign cbus_okay = ((state == br_transfer) && beat_hs && !(cbus_is_write && is_last)) ||
                       ((state == br_waiting) && b_hs);
    assign cbus_last  = cbus_okay && is_final;
    assign cbus_rdata = axi.r_data;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= br_idle;
            round_cnt <= '0;
            len_cnt   <= '0;
        end else begin
            unique case (state)
                br_idle: begin
                    if (cbus_valid && addr_hs) begin
                        state     <= br_transfer;
                        round_cnt <= num_round;
                        len_cnt   <= burst_len;
                    end
                end

                br_transfer: begin
                    if (beat_hs) begin
                        if (!is_last) begin
                            len_cnt <= len_cnt - 1'b1;
                        end else if (cbus_is_write) begin
                            state <= br_waiting;
                        end else if (is_final) begin
                            state <= br_idle;
                        end else begin
                            state <= br_request;
                        end
                    end
                end

                br_request: begin
                    if (addr_hs) begin
                        state     <= br_transfer;
                        round_cnt <= round_cnt - 1'b1;
                        len_cnt   <= burst_len;
                    end
                end

                br_waiting: begin
                    if (b_hs) begin
                        state <= is_final ? br_idle : br_request;
                    end
                end
            endcase
        end
    end

    // burst address, stepped at the end of every burst
    always_ff @(posedge clk) begin
        if (state == br_idle && addr_hs) begin
            current_addr <= cbus_addr;
        end else if (state == br_transfer && beat_hs && is_last) begin
            current_addr <= current_addr + addr_step;
        end
    end

endmodule
